// File: bitmap_arbiter.sv
// bitmap arbiter
// painter reads own the store during active video, a host row write is
// held in a one-entry register until the painter stops reading
`timescale 1ns/10ps
`include "hello_settings.svh"

module bitmap_arbiter (
	input  logic clk_pix,
	input  logic arst_n,
	input  logic rd_en,
	input  logic [3:0] rd_row,
	output logic [`BMAP_W-1:0] rd_bits,
	input  logic wr_strobe,
	input  hello_pkg::bmap_wr_t wr_req,
	output logic wr_pending,
	output logic st_rd_en,
	output logic [3:0] st_rd_row,
	input  logic [`BMAP_W-1:0] st_rd_bits,
	output logic st_wr_en,
	output hello_pkg::bmap_wr_t st_wr
);
	import hello_pkg::*;

	bmap_wr_t held; // last captured host write
	logic [$clog2(`H_TOTAL+1)-1:0] wait_cnt; // cycles spent waiting for a grant

	assign st_rd_en  = rd_en;  // painter always wins
	assign st_rd_row = rd_row;
	assign rd_bits   = st_rd_bits;
	assign st_wr_en  = wr_pending && !rd_en; // grant in blanking only
	assign st_wr     = held;

	always_ff @(posedge clk_pix) begin
		if (wr_strobe && (wr_req.row < `BMAP_H))
			held <= wr_req; // newer strobe replaces the held one
	end

	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			wr_pending <= 1'b0;
			wait_cnt   <= '0;
		end else begin
			if (wr_strobe && (wr_req.row < `BMAP_H))
				wr_pending <= 1'b1; // rows past the bitmap are dropped
			else if (st_wr_en)
				wr_pending <= 1'b0;
			if (wr_pending && !st_wr_en)
				wait_cnt <= wait_cnt + 1'b1;
			else
				wait_cnt <= '0;
		end
	end

	// active video never lasts a whole line
	a_grant_wait: assert property (@(posedge clk_pix) disable iff (!arst_n)
		wait_cnt < `H_TOTAL)
		else $error("held bitmap write not granted within a line");

endmodule

// File: bitmap_painter.sv
// bitmap painter
// maps the beam to a 32x32 bitmap cell, fetches its row and paints
// yellow on blue, three cycles behind the position with matching sync
`timescale 1ns/10ps
`include "hello_settings.svh"

module bitmap_painter (
	input  logic clk_pix,
	input  logic arst_n,
	input  hello_pkg::screen_pos_t pos,
	input  hello_pkg::sync_t sync,
	output logic rd_en,
	output logic [3:0] rd_row,
	input  logic [`BMAP_W-1:0] rd_bits,
	output hello_pkg::rgb_t pix,
	output hello_pkg::sync_t pix_sync
);
	import hello_pkg::*;

	logic [`CORDW-1:0] cell_x, cell_y; // unscaled cell coordinates
	logic in_map;
	logic [4:0] col1, col2; // 20 columns need five bits
	logic [3:0] row1;
	logic map1, map2; // cell lies inside the bitmap
	sync_t sync1, sync2;
	logic lit;

	always_comb begin
		cell_x = pos.sx >> `SCALE_SHIFT;
		cell_y = pos.sy >> `SCALE_SHIFT;
		in_map = (cell_x < `BMAP_W) && (cell_y < `BMAP_H); // right and lower screen is empty
	end

	// sync pipe and cell valid flags
	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			sync1    <= '0;
			sync2    <= '0;
			pix_sync <= '0;
			map1     <= 1'b0;
			map2     <= 1'b0;
		end else begin
			sync1    <= sync;
			sync2    <= sync1;
			pix_sync <= sync2;
			map1     <= in_map;
			map2     <= map1;
		end
	end

	// stage one cell index, clamped so the store index stays in range
	always_ff @(posedge clk_pix) begin
		col1 <= in_map ? cell_x[4:0] : '0;
		row1 <= in_map ? cell_y[3:0] : '0;
		col2 <= col1; // lines up with the returned row
	end

	assign rd_en  = sync1.de; // read through the whole active line
	assign rd_row = row1;

	assign lit = map2 && rd_bits[`BMAP_W-1-col2];

	// stage three colour
	always_ff @(posedge clk_pix) begin
		if (!sync2.de)
			pix <= '0; // black in blanking
		else if (lit)
			pix <= {`COL_FG_R, `COL_FG_G, `COL_FG_B};
		else
			pix <= {`COL_BG_R, `COL_BG_G, `COL_BG_B};
	end

endmodule

// File: bitmap_store.sv
// bitmap store
// 20x15 one-bit image rows with a registered read, preloaded with HELLO WORLD
`timescale 1ns/10ps
`include "hello_settings.svh"

module bitmap_store (
	input  logic clk_pix,
	input  logic rd_en,
	input  logic [3:0] rd_row,
	output logic [`BMAP_W-1:0] rd_bits,
	input  logic wr_en,
	input  hello_pkg::bmap_wr_t wr
);

	logic [`BMAP_W-1:0] rows [`BMAP_H]; // msb is the leftmost cell

	initial begin
		for (int i = 0; i < `BMAP_H; i++)
			rows[i] = '0;
		rows[0]  = 20'hAE886; // HELLO
		rows[1]  = 20'hA888A;
		rows[2]  = 20'hEC88A;
		rows[3]  = 20'hA888A;
		rows[4]  = 20'hAEEEC;
		rows[6]  = 20'hA6E8C; // WORLD
		rows[7]  = 20'hAAA8A;
		rows[8]  = 20'hAAC8A;
		rows[9]  = 20'hEAA8A;
		rows[10] = 20'hECAEE;
	end

	always_ff @(posedge clk_pix) begin
		if (rd_en)
			rd_bits <= rows[rd_row]; // data one cycle later
		if (wr_en)
			rows[wr.row] <= wr.bits;
	end

	// the arbiter keeps painter reads and host writes apart
	a_no_collide: assert property (@(posedge clk_pix) !(rd_en && wr_en))
		else $error("bitmap read and write in the same cycle");

endmodule

// File: display_timing.sv
// display timing generator
// scans 1280x720 and decodes hsync, vsync and data enable from the position
`timescale 1ns/10ps
`include "hello_settings.svh"

module display_timing (
	input  logic clk_pix,
	input  logic arst_n,
	output hello_pkg::screen_pos_t pos,
	output hello_pkg::sync_t sync
);

	localparam logic [`CORDW-1:0] H_LAST = `H_TOTAL - 1; // last pixel of a line
	localparam logic [`CORDW-1:0] V_LAST = `V_TOTAL - 1; // last line of a frame
	localparam logic [`CORDW-1:0] H_ACT = `H_ACTIVE;
	localparam logic [`CORDW-1:0] V_ACT = `V_ACTIVE;
	localparam logic [`CORDW-1:0] HS_STA = `H_ACTIVE + `H_FP;
	localparam logic [`CORDW-1:0] HS_END = `H_ACTIVE + `H_FP + `H_SYNC;
	localparam logic [`CORDW-1:0] VS_STA = `V_ACTIVE + `V_FP;
	localparam logic [`CORDW-1:0] VS_END = `V_ACTIVE + `V_FP + `V_SYNC;

	// position counters, frame starts in the active area
	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			pos.sx <= '0;
			pos.sy <= '0;
		end else if (pos.sx == H_LAST) begin
			pos.sx <= '0; // end of line
			if (pos.sy == V_LAST)
				pos.sy <= '0; // end of frame
			else
				pos.sy <= pos.sy + 1'b1;
		end else begin
			pos.sx <= pos.sx + 1'b1;
		end
	end

	// sync decode, back porch is the remainder of each total
	always_comb begin
		sync.hsync = (pos.sx >= HS_STA) && (pos.sx < HS_END);
		sync.vsync = (pos.sy >= VS_STA) && (pos.sy < VS_END);
		sync.de    = (pos.sx < H_ACT) && (pos.sy < V_ACT); // visible pixel
	end

	// line counter must wrap before the total
	a_sx_wrap: assert property (@(posedge clk_pix) disable iff (!arst_n)
		pos.sx < `H_TOTAL)
		else $error("sx reached H_TOTAL");

endmodule

// File: hello_pkg.sv
// hello display types
// structs shared by the timing generator, painter, bitmap path and encoders
`include "hello_settings.svh"

package hello_pkg;

	// current beam position
	typedef struct packed {
		logic [`CORDW-1:0] sx; // column
		logic [`CORDW-1:0] sy; // line
	} screen_pos_t;

	// sync and data enable, all active high
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} sync_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// one bitmap row write, msb is the leftmost cell
	typedef struct packed {
		logic [3:0] row;
		logic [`BMAP_W-1:0] bits;
	} bmap_wr_t;

	typedef logic [9:0] tmds_sym_t; // bit 0 is sent first

endpackage

// File: hello_settings.svh
// hello display settings
// 720p timing, bitmap geometry and paint colours for the DVI hello pipeline
`ifndef HELLO_SETTINGS_SVH
`define HELLO_SETTINGS_SVH

`define CORDW 12 // screen coordinate width in bits

// horizontal timing in pixels, positive sync
`define H_ACTIVE 1280
`define H_FP 110
`define H_SYNC 40
`define H_BP 220
`define H_TOTAL 1650

// vertical timing in lines, positive sync
`define V_ACTIVE 720
`define V_FP 5
`define V_SYNC 5
`define V_BP 20
`define V_TOTAL 750

`define BMAP_W 20 // bitmap columns
`define BMAP_H 15 // bitmap rows
`define SCALE_SHIFT 5 // each cell covers 32x32 pixels

`define COL_FG_R 8'hF0 // yellow letters
`define COL_FG_G 8'hC0
`define COL_FG_B 8'h00
`define COL_BG_R 8'h10 // dark blue background
`define COL_BG_G 8'h30
`define COL_BG_B 8'h70

`endif

// File: run_sim.sh
#!/bin/sh
# build the hello display testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module tb_top_hello -f top_hello.f -o sim_top_hello \
	&& ./obj_dir/sim_top_hello > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1

// File: tb_clock.sv
// testbench clock and reset
// 100 ns pixel clock, reset held low for the first 8 cycles
`timescale 1ns/10ps

module tb_clock (
	output logic clk_pix,
	output logic arst_n
);

	initial begin
		clk_pix = 1'b0;
		forever #50 clk_pix = ~clk_pix;
	end

	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk_pix);
		#10 arst_n = 1'b1; // released clear of the edge
	end

endmodule

// File: tb_top_hello.sv
// hello display testbench
// directed tests on the TMDS symbols with a reference decoder and an image model
`timescale 1ns/10ps
`include "hello_settings.svh"

module tb_top_hello;
	import hello_pkg::*;

	localparam int LINE = `H_TOTAL;
	localparam int FRAME = `H_TOTAL * `V_TOTAL;
	localparam int TIMEOUT = 3 * FRAME + 50 * LINE; // tests end early in the fourth frame
	localparam tmds_sym_t CODE_00 = 10'b1101010100; // DVI control codes for {c1, c0}
	localparam tmds_sym_t CODE_01 = 10'b0010101011;
	localparam tmds_sym_t CODE_10 = 10'b0101010100;
	localparam tmds_sym_t CODE_11 = 10'b1010101011;

	logic clk_pix, arst_n, wr_strobe, wr_pending;
	bmap_wr_t wr_req;
	tmds_sym_t tmds_r, tmds_g, tmds_b;
	logic [`BMAP_W-1:0] bmap [`BMAP_H]; // expected image with msb leftmost
	int errors = 0;
	int cycles = 0;
	int idx = 0; // screen index of the symbols now on the outputs
	logic [31:0] rng = 32'h2a44144e;

	tb_clock clock_gen (.clk_pix, .arst_n);

	top_hello dut (.clk_pix, .arst_n, .wr_strobe, .wr_req, .wr_pending,
		.tmds_r, .tmds_g, .tmds_b);

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	function automatic logic is_ctrl(tmds_sym_t s);
		return (s == CODE_00) || (s == CODE_01) || (s == CODE_10) || (s == CODE_11);
	endfunction

	function automatic logic [1:0] ctrl_of(tmds_sym_t s);
		case (s)
			CODE_01: return 2'b01;
			CODE_10: return 2'b10;
			CODE_11: return 2'b11;
			default: return 2'b00;
		endcase
	endfunction

	// TMDS picks xnor for more than four ones or for four ones with bit 0 clear
	function automatic logic xor_flag(logic [7:0] d);
		int n;
		n = $countones(d);
		return !((n > 4) || ((n == 4) && !d[0]));
	endfunction

	// reference decoder undoes the inversion then the xor or xnor chain
	function automatic logic [7:0] tmds_decode(tmds_sym_t s);
		logic [7:0] d;
		logic [7:0] q;
		d = s[9] ? ~s[7:0] : s[7:0];
		q[0] = d[0];
		for (int i = 1; i < 8; i++)
			q[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]); // bit 8 set means xor
		return q;
	endfunction

	function automatic rgb_t decoded_rgb();
		return {tmds_decode(tmds_r), tmds_decode(tmds_g), tmds_decode(tmds_b)};
	endfunction

	// expected colour from the image model with one cell per 32x32 block
	function automatic rgb_t paint_colour(int sx, int sy);
		int cx, cy;
		cx = sx >> `SCALE_SHIFT;
		cy = sy >> `SCALE_SHIFT;
		if (sx >= `H_ACTIVE || sy >= `V_ACTIVE)
			return '0;
		if (cx < `BMAP_W && cy < `BMAP_H && bmap[cy[3:0]][5'(`BMAP_W - 1 - cx)])
			return {`COL_FG_R, `COL_FG_G, `COL_FG_B};
		return {`COL_BG_R, `COL_BG_G, `COL_BG_B};
	endfunction

	task automatic load_image();
		for (int i = 0; i < `BMAP_H; i++)
			bmap[i] = '0;
		bmap[0] = 20'hAE886; // HELLO
		bmap[1] = 20'hA888A;
		bmap[2] = 20'hEC88A;
		bmap[3] = 20'hA888A;
		bmap[4] = 20'hAEEEC;
		bmap[6] = 20'hA6E8C; // WORLD
		bmap[7] = 20'hAAA8A;
		bmap[8] = 20'hAAC8A;
		bmap[9] = 20'hEAA8A;
		bmap[10] = 20'hECAEE;
	endtask

	task automatic step(); // next edge then 10 ns on, where outputs are sampled and inputs driven
		@(posedge clk_pix);
		#10;
		idx++;
	endtask

	task automatic run_to(int target);
		while (idx < target)
			step();
	endtask

	task automatic check_sym(string name, tmds_sym_t exp, tmds_sym_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_rgb(string name, rgb_t exp, rgb_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	// every active pixel of one line against the image model
	task automatic check_line(string name, int start);
		run_to(start);
		while (idx < start + `H_ACTIVE) begin
			check_rgb($sformatf("%s (%0d,%0d)", name, idx % LINE, (idx / LINE) % `V_TOTAL),
				paint_colour(idx % LINE, (idx / LINE) % `V_TOTAL), decoded_rgb());
			step();
		end
	endtask

	task automatic test_reset_ctrl();
		wait (arst_n === 1'b1);
		check_sym("reset_ctrl red", CODE_00, tmds_r);
		check_sym("reset_ctrl green", CODE_00, tmds_g);
		check_sym("reset_ctrl blue", CODE_00, tmds_b);
		check_bit("reset_ctrl pending", 1'b0, wr_pending);
		while (is_ctrl(tmds_b))
			step();
		idx = 0; // first active symbol is pixel (0,0) of frame 0
	endtask

	task automatic test_pixels();
		while (idx < 480 * LINE) begin
			if ((idx % LINE) < `H_ACTIVE && (idx / LINE) % 8 == 4 && (idx % LINE) % 4 == 2)
				check_rgb($sformatf("pixels (%0d,%0d)", idx % LINE, idx / LINE),
					paint_colour(idx % LINE, idx / LINE), decoded_rgb());
			step();
		end
	endtask

	task automatic test_dc_balance();
		int disp [3];
		tmds_sym_t s [3];
		rgb_t bg;
		logic [7:0] d [3];
		disp = '{0, 0, 0};
		run_to(500 * LINE);
		while (idx < 500 * LINE + `H_ACTIVE) begin
			s = '{tmds_r, tmds_g, tmds_b};
			for (int c = 0; c < 3; c++) begin
				disp[c] += 2 * $countones(s[c]) - 10; // ones minus zeros of the symbol
				if (disp[c] > 10 || disp[c] < -10) begin
					errors++;
					$display("dc balance: channel %0d drifted to %0d at pixel %0d", c, disp[c],
						idx % LINE);
				end
			end
			step();
		end
		s = '{tmds_r, tmds_g, tmds_b};
		for (int c = 0; c < 3; c++)
			check_bit($sformatf("dc_balance blank ch%0d", c), 1'b1, is_ctrl(s[c]));
		run_to(501 * LINE);
		s = '{tmds_r, tmds_g, tmds_b};
		bg = paint_colour(0, 501);
		d = '{bg.r, bg.g, bg.b};
		for (int c = 0; c < 3; c++) // zero disparity sends bit 9 as the inverse of the xor flag
			check_bit($sformatf("dc_balance restart ch%0d", c), ~xor_flag(d[c]), s[c][9]);
	endtask

	task automatic test_line_timing();
		int prev_start, hs_len, vs_start;
		logic hs, vs, hs_q, vs_q;
		logic [1:0] code;
		prev_start = -1;
		vs_start = -1;
		hs_len = 0;
		hs_q = 1'b0;
		vs_q = 1'b0;
		run_to(700 * LINE);
		while (idx < FRAME + 3 * LINE) begin
			code = ctrl_of(tmds_b);
			hs = is_ctrl(tmds_b) && code[0]; // c0 carries hsync
			vs = is_ctrl(tmds_b) && code[1];
			if (hs && !hs_q) begin
				check_count("line_timing hsync start", `H_ACTIVE + `H_FP, idx % LINE);
				if (prev_start >= 0)
					check_count("line_timing hsync period", LINE, idx - prev_start);
				prev_start = idx;
				hs_len = 0;
			end
			if (hs)
				hs_len++;
			else if (hs_q)
				check_count("line_timing hsync width", `H_SYNC, hs_len);
			if (vs && !vs_q) begin
				check_count("line_timing vsync line", `V_ACTIVE + `V_FP, idx / LINE);
				vs_start = idx;
			end
			if (!vs && vs_q)
				check_count("line_timing vsync length", `V_SYNC * LINE, idx - vs_start);
			hs_q = hs;
			vs_q = vs;
			step();
		end
		if (prev_start < 0 || vs_start < 0) begin
			errors++;
			$display("line timing: no hsync or vsync code seen on the blue channel");
		end
	endtask

	task automatic test_held_write();
		bmap_wr_t w;
		int t0;
		w.row = 4'(next_rand() % 15);
		w.bits = 20'(next_rand() >> 12);
		t0 = FRAME + 100 * LINE + 600; // middle of an active line
		run_to(t0);
		wr_req = w;
		wr_strobe = 1'b1;
		step();
		wr_strobe = 1'b0;
		bmap[w.row] = w.bits;
		// reads run three pixels ahead of the symbols
		// pending drops a cycle after the grant
		while (idx < t0 - 600 + `H_ACTIVE + 20) begin
			check_bit($sformatf("held_write pending sx %0d", idx % LINE),
				(idx % LINE) + 2 < `H_ACTIVE, wr_pending);
			step();
		end
		check_line("held_write row", 2 * FRAME + (w.row * 32 + 16) * LINE);
	endtask

	task automatic test_blank_write();
		bmap_wr_t w;
		w.row = 4'd0;
		w.bits = 20'(next_rand() >> 12);
		run_to(2 * FRAME + 735 * LINE + 100); // vertical blanking
		wr_req = w;
		wr_strobe = 1'b1;
		step();
		wr_strobe = 1'b0;
		bmap[0] = w.bits;
		check_bit("blank_write pending set", 1'b1, wr_pending);
		run_to(3 * FRAME - 4); // painter reads start right after this
		check_bit("blank_write pending clear", 1'b0, wr_pending);
		check_line("blank_write row 0", 3 * FRAME + 16 * LINE);
	endtask

	initial begin
		wr_strobe = 1'b0;
		wr_req = '0;
		load_image();
		test_reset_ctrl();
		test_pixels();
		test_dc_balance();
		test_line_timing();
		test_held_write();
		test_blank_write();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// run limit
	always @(posedge clk_pix) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("errors: %0d", errors);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

// File: tmds_encoder.sv
// TMDS encoder
// DVI 8b/10b for one channel, transition minimising then DC balancing
// with a running disparity, control symbols during blanking
`timescale 1ns/10ps

module tmds_encoder (
	input  logic clk_pix,
	input  logic arst_n,
	input  logic [7:0] data,
	input  logic [1:0] ctrl, // {c1, c0}
	input  logic de,
	output hello_pkg::tmds_sym_t sym
);
	import hello_pkg::*;

	localparam tmds_sym_t CTRL_00 = 10'b1101010100;
	localparam tmds_sym_t CTRL_01 = 10'b0010101011;
	localparam tmds_sym_t CTRL_10 = 10'b0101010100;
	localparam tmds_sym_t CTRL_11 = 10'b1010101011;

	logic [3:0] n1_d, n1_q; // ones in data and in q_m[7:0]
	logic use_xnor;
	logic [8:0] q_m;
	logic signed [5:0] bal; // ones minus zeros of q_m[7:0]
	logic signed [5:0] cnt, cnt_next; // running disparity
	tmds_sym_t sym_next;

	// stage one of the DVI algorithm, fewer transitions
	always_comb begin
		n1_d = 4'($countones(data));
		use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data[0]);
		q_m[0] = data[0];
		for (int i = 1; i < 8; i++) begin
			if (use_xnor)
				q_m[i] = ~(q_m[i-1] ^ data[i]);
			else
				q_m[i] = q_m[i-1] ^ data[i];
		end
		q_m[8] = !use_xnor; // 1 marks xor
	end

	// stage two, DC balance
	always_comb begin
		n1_q = 4'($countones(q_m[7:0]));
		bal  = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;
		if ((cnt == 0) || (bal == 0)) begin
			sym_next = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
			cnt_next = q_m[8] ? (cnt + bal) : (cnt - bal);
		end else if (((cnt > 0) && (bal > 0)) || ((cnt < 0) && (bal < 0))) begin
			sym_next = {1'b1, q_m[8], ~q_m[7:0]}; // invert to pull back
			cnt_next = cnt + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
		end else begin
			sym_next = {1'b0, q_m[8], q_m[7:0]};
			cnt_next = cnt - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
		end
	end

	always_ff @(posedge clk_pix or negedge arst_n) begin
		if (!arst_n) begin
			sym <= CTRL_00;
			cnt <= '0;
		end else if (!de) begin
			cnt <= '0; // disparity restarts each blanking
			case (ctrl)
				2'b00: sym <= CTRL_00;
				2'b01: sym <= CTRL_01;
				2'b10: sym <= CTRL_10;
				default: sym <= CTRL_11;
			endcase
		end else begin
			sym <= sym_next;
			cnt <= cnt_next;
		end
	end

endmodule

// File: top_hello.f
+incdir+.
hello_pkg.sv
display_timing.sv
bitmap_store.sv
bitmap_arbiter.sv
bitmap_painter.sv
tmds_encoder.sv
top_hello.sv
tb_clock.sv
tb_top_hello.sv

// File: top_hello.sv
// hello display top level
// timing, bitmap painter with shared store and three TMDS channels,
// pixel at (sx, sy) reaches the symbols four cycles after the counters
`timescale 1ns/10ps
`include "hello_settings.svh"

module top_hello (
	input  logic clk_pix,
	input  logic arst_n,
	input  logic wr_strobe, // one-cycle host write
	input  hello_pkg::bmap_wr_t wr_req,
	output logic wr_pending,
	output hello_pkg::tmds_sym_t tmds_r,
	output hello_pkg::tmds_sym_t tmds_g,
	output hello_pkg::tmds_sym_t tmds_b
);
	import hello_pkg::*;

	screen_pos_t pos;
	sync_t sync, pix_sync;
	rgb_t pix;
	logic rd_en, st_rd_en, st_wr_en;
	logic [3:0] rd_row, st_rd_row;
	logic [`BMAP_W-1:0] rd_bits, st_rd_bits;
	bmap_wr_t st_wr;

	display_timing timing_inst (.clk_pix, .arst_n, .pos, .sync);

	bitmap_painter painter_inst (
		.clk_pix, .arst_n, .pos, .sync,
		.rd_en, .rd_row, .rd_bits,
		.pix, .pix_sync
	);

	bitmap_arbiter arbiter_inst (
		.clk_pix, .arst_n,
		.rd_en, .rd_row, .rd_bits,
		.wr_strobe, .wr_req, .wr_pending,
		.st_rd_en, .st_rd_row, .st_rd_bits, .st_wr_en, .st_wr
	);

	bitmap_store store_inst (
		.clk_pix, .rd_en(st_rd_en), .rd_row(st_rd_row), .rd_bits(st_rd_bits),
		.wr_en(st_wr_en), .wr(st_wr)
	);

	// sync rides on the blue channel
	tmds_encoder enc_b (.clk_pix, .arst_n, .data(pix.b),
		.ctrl({pix_sync.vsync, pix_sync.hsync}), .de(pix_sync.de), .sym(tmds_b));
	tmds_encoder enc_g (.clk_pix, .arst_n, .data(pix.g),
		.ctrl(2'b00), .de(pix_sync.de), .sym(tmds_g));
	tmds_encoder enc_r (.clk_pix, .arst_n, .data(pix.r),
		.ctrl(2'b00), .de(pix_sync.de), .sym(tmds_r));

endmodule
